// ==== common/cpu_addr_pkg.sv ====
package cpu_addr_pkg;

	// ==============================
	// Processor address space
	// ==============================

	// Width of a byte address as seen by the fetch unit
	localparam int ADDR_W = 32;

	// Byte address used for both virtual and physical addresses
	typedef logic [ADDR_W-1:0] address_t;

	// The page offset covers bits 11 down to 0
	// Cache index bits are kept below this boundary so that the virtual and
	// the physical index of a line are always the same
	localparam int PAGE_BITS = 12;

endpackage

// ==== common/cache_cfg_pkg.sv ====
package cache_cfg_pkg;

	// ==============================
	// Cache geometry
	// ==============================

	// Lowest index bit, which gives a 64 byte line
	localparam int LOBIT = 6;

	// Associativity is fixed
	localparam int WAYS = 4;

	// Lowest tag bit for the default of 64 sets
	// Bit 12 sits between the index and the tag and selects odd or even lines
	localparam int TAG_LOBIT = cpu_addr_pkg::PAGE_BITS + 1;

	// Tag width, bits 31 down to 13
	localparam int TAG_W = cpu_addr_pkg::ADDR_W - TAG_LOBIT;

	// Number of data bits in one line
	localparam int LINE_W = 8 << LOBIT;

	// ==============================
	// Types
	// ==============================

	// Way number, two bits for four ways
	typedef logic [$clog2(WAYS)-1:0] way_t;

	// One stored tag, virtual or physical
	typedef logic [TAG_W-1:0] cache_tag_t;

	// One full cache line
	typedef logic [LINE_W-1:0] line_t;

	// A virtual tag of one marks an empty way
	// No valid fetch address ever carries this tag
	localparam cache_tag_t TAG_INVALID = cache_tag_t'(1);

endpackage

// ==== common/cache_fill_if.sv ====
// One fill write, issued by the fill controller and taken by both the tag
// store and the data store in the same cycle
interface cache_fill_if;

	// Write strobe, one cycle per line
	logic wr;

	// Way that receives the line
	cache_cfg_pkg::way_t way;

	// Virtual address of the line, which also gives the index
	cpu_addr_pkg::address_t vadr;

	// Physical address of the line, only its tag part is stored
	cpu_addr_pkg::address_t padr;

	// Line data
	cache_cfg_pkg::line_t line;

	// The controller drives every signal
	modport ctrl (output wr, way, vadr, padr, line);

	// The arrays only listen
	modport array (input wr, way, vadr, padr, line);

endinterface

// ==== cache_tag/cache_tag_store.sv ====
module cache_tag_store #(
	parameter int LINES = 64
) (
	input  logic clk,
	input  logic rst,
	input  logic ce_i,
	cache_fill_if.array fill,
	input  logic [$clog2(LINES)-1:0] ndx_i,
	input  logic inv_i,
	input  cache_cfg_pkg::way_t inv_way_i,
	input  logic [$clog2(LINES)-1:0] inv_ndx_i,
	output cache_cfg_pkg::cache_tag_t [cache_cfg_pkg::WAYS-1:0] vtag_o,
	output cache_cfg_pkg::cache_tag_t ptag_o [cache_cfg_pkg::WAYS][LINES]
);

	// ==============================
	// Address fields
	// ==============================

	localparam int NDX_W = $clog2(LINES);
	localparam int HIBIT = cache_cfg_pkg::LOBIT + NDX_W - 1;
	// One extra bit is skipped above the index for odd/even lines
	localparam int TAGBIT = HIBIT + 2;

	// Virtual tags are reset so that every way starts empty
	cache_cfg_pkg::cache_tag_t vtags [cache_cfg_pkg::WAYS][LINES];

	// Physical tags are only meaningful while the matching virtual tag is valid
	cache_cfg_pkg::cache_tag_t ptags [cache_cfg_pkg::WAYS][LINES];

	logic [NDX_W-1:0] fill_ndx;
	cache_cfg_pkg::cache_tag_t fill_vtag;
	cache_cfg_pkg::cache_tag_t fill_ptag;

	// The fill index comes from the virtual address
	// Index bits lie inside the page offset, so the physical index is the same
	assign fill_ndx = fill.vadr[HIBIT:cache_cfg_pkg::LOBIT];

	// Tags are cut from the top of each address
	assign fill_vtag = cache_cfg_pkg::cache_tag_t'(fill.vadr[cpu_addr_pkg::ADDR_W-1:TAGBIT]);
	assign fill_ptag = cache_cfg_pkg::cache_tag_t'(fill.padr[cpu_addr_pkg::ADDR_W-1:TAGBIT]);

	// ==============================
	// Virtual tag array
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < cache_cfg_pkg::WAYS; w++) begin
				for (int n = 0; n < LINES; n++) begin
					vtags[w][n] <= cache_cfg_pkg::TAG_INVALID;
				end
			end
		end else if (ce_i) begin
			// Snoop invalidation marks one way empty
			if (inv_i) begin
				vtags[inv_way_i][inv_ndx_i] <= cache_cfg_pkg::TAG_INVALID;
			end
			// The fill comes last so it overrides an invalidation of the same entry
			if (fill.wr) begin
				vtags[fill.way][fill_ndx] <= fill_vtag;
			end
		end
	end

	// ==============================
	// Physical tag array
	// ==============================

	always_ff @(posedge clk) begin
		if (ce_i && fill.wr) begin
			ptags[fill.way][fill_ndx] <= fill_ptag;
		end
	end

	// Snoops search every line, so the whole array is visible to the matcher
	assign ptag_o = ptags;

	// Asynchronous read of all ways at the requested index
	always_comb begin
		for (int w = 0; w < cache_cfg_pkg::WAYS; w++) begin
			vtag_o[w] = vtags[w][ndx_i];
		end
	end

endmodule

// ==== cache_tag/cache_tag_match.sv ====
module cache_tag_match #(
	parameter int LINES = 64
) (
	input  logic clk,
	input  logic rst,
	input  logic ce_i,
	input  logic lookup_i,
	input  cpu_addr_pkg::address_t lookup_adr_i,
	input  logic snoop_i,
	input  cpu_addr_pkg::address_t snoop_adr_i,
	input  cache_cfg_pkg::cache_tag_t [cache_cfg_pkg::WAYS-1:0] vtag_i,
	input  cache_cfg_pkg::cache_tag_t ptag_i [cache_cfg_pkg::WAYS][LINES],
	output logic inv_o,
	output cache_cfg_pkg::way_t inv_way_o,
	output logic [$clog2(LINES)-1:0] inv_ndx_o,
	output logic lookup_valid_o,
	output logic hit_o,
	output cache_cfg_pkg::way_t hit_way_o,
	output logic snoop_valid_o,
	output logic snoop_hit_o
);

	localparam int NDX_W = $clog2(LINES);
	localparam int HIBIT = cache_cfg_pkg::LOBIT + NDX_W - 1;
	localparam int TAGBIT = HIBIT + 2;

	cache_cfg_pkg::cache_tag_t lookup_tag;
	cache_cfg_pkg::cache_tag_t snoop_tag;
	logic [NDX_W-1:0] snoop_ndx;
	logic [cache_cfg_pkg::WAYS-1:0] lk_match;
	logic [cache_cfg_pkg::WAYS-1:0] sn_match;
	cache_cfg_pkg::way_t lk_way;
	cache_cfg_pkg::way_t sn_way;

	assign lookup_tag = cache_cfg_pkg::cache_tag_t'(lookup_adr_i[cpu_addr_pkg::ADDR_W-1:TAGBIT]);
	assign snoop_tag = cache_cfg_pkg::cache_tag_t'(snoop_adr_i[cpu_addr_pkg::ADDR_W-1:TAGBIT]);
	assign snoop_ndx = snoop_adr_i[HIBIT:cache_cfg_pkg::LOBIT];

	// ==============================
	// Tag compare
	// ==============================

	// Lookup compares against the virtual tags
	// An empty way holds the marker, which no lookup tag equals
	// Snoop compares against the physical tags, but only where the way is still valid
	always_comb begin
		for (int w = 0; w < cache_cfg_pkg::WAYS; w++) begin
			lk_match[w] = (vtag_i[w] == lookup_tag);
			sn_match[w] = (ptag_i[w][snoop_ndx] == snoop_tag) &&
				(vtag_i[w] != cache_cfg_pkg::TAG_INVALID);
		end
	end

	// Lowest matching way wins, scanning down so the last write is way zero
	always_comb begin
		lk_way = '0;
		sn_way = '0;
		for (int w = cache_cfg_pkg::WAYS - 1; w >= 0; w--) begin
			if (lk_match[w]) begin
				lk_way = cache_cfg_pkg::way_t'(w);
			end
			if (sn_match[w]) begin
				sn_way = cache_cfg_pkg::way_t'(w);
			end
		end
	end

	// Invalidation request goes straight back to the tag store in the same cycle
	assign inv_o = snoop_i && (|sn_match);
	assign inv_way_o = sn_way;
	assign inv_ndx_o = snoop_ndx;

	// ==============================
	// Registered results
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			lookup_valid_o <= 1'b0;
			hit_o <= 1'b0;
			snoop_valid_o <= 1'b0;
			snoop_hit_o <= 1'b0;
		end else if (ce_i) begin
			lookup_valid_o <= lookup_i;
			hit_o <= lookup_i && (|lk_match);
			snoop_valid_o <= snoop_i;
			snoop_hit_o <= inv_o;
		end
	end

	// The hit way also selects the line in the data store
	always_ff @(posedge clk) begin
		if (ce_i && lookup_i) begin
			hit_way_o <= lk_way;
		end
	end

endmodule

// ==== logic/cache_fill_ctrl.sv ====
module cache_fill_ctrl #(
	parameter int LINES = 64
) (
	input  logic clk,
	input  logic rst,
	input  logic ce_i,
	input  logic fill_i,
	input  cpu_addr_pkg::address_t fill_vadr_i,
	input  cpu_addr_pkg::address_t fill_padr_i,
	input  cache_cfg_pkg::line_t fill_line_i,
	cache_fill_if.ctrl fill
);

	localparam int NDX_W = $clog2(LINES);
	localparam int HIBIT = cache_cfg_pkg::LOBIT + NDX_W - 1;

	// ==============================
	// Replacement pointers
	// ==============================

	// One round-robin pointer per set, it names the way the next fill replaces
	cache_cfg_pkg::way_t ptr [LINES];

	logic [NDX_W-1:0] fill_ndx;

	assign fill_ndx = fill_vadr_i[HIBIT:cache_cfg_pkg::LOBIT];

	// Pointer moves on only when the fill is actually taken
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int n = 0; n < LINES; n++) begin
				ptr[n] <= '0;
			end
		end else if (ce_i && fill_i) begin
			// Two bit pointer wraps from way three back to way zero
			ptr[fill_ndx] <= cache_cfg_pkg::way_t'(ptr[fill_ndx] + 1'b1);
		end
	end

	// ==============================
	// Fill write
	// ==============================

	// Write goes out in the same cycle as the request
	// Both arrays apply their own clock enable
	assign fill.wr = fill_i;
	assign fill.way = ptr[fill_ndx];
	assign fill.vadr = fill_vadr_i;
	assign fill.padr = fill_padr_i;
	assign fill.line = fill_line_i;

endmodule

// ==== logic/cache_data_store.sv ====
module cache_data_store #(
	parameter int LINES = 64
) (
	input  logic clk,
	input  logic ce_i,
	cache_fill_if.array fill,
	input  logic rd_i,
	input  logic [$clog2(LINES)-1:0] rd_ndx_i,
	input  cache_cfg_pkg::way_t rd_way_i,
	output cache_cfg_pkg::line_t line_o
);

	localparam int NDX_W = $clog2(LINES);
	localparam int HIBIT = cache_cfg_pkg::LOBIT + NDX_W - 1;

	// ==============================
	// Line arrays
	// ==============================

	// One line array per way
	cache_cfg_pkg::line_t lines [cache_cfg_pkg::WAYS][LINES];

	// Lines of all ways at the last read index
	cache_cfg_pkg::line_t rd_q [cache_cfg_pkg::WAYS];

	logic [NDX_W-1:0] fill_ndx;

	// Same index as the tag store uses for the fill
	assign fill_ndx = fill.vadr[HIBIT:cache_cfg_pkg::LOBIT];

	always_ff @(posedge clk) begin
		if (ce_i && fill.wr) begin
			lines[fill.way][fill_ndx] <= fill.line;
		end
	end

	// ==============================
	// Registered read
	// ==============================

	// The way is not known yet when the read starts
	// so every way is read and the pick happens one cycle later
	always_ff @(posedge clk) begin
		if (ce_i && rd_i) begin
			for (int w = 0; w < cache_cfg_pkg::WAYS; w++) begin
				rd_q[w] <= lines[w][rd_ndx_i];
			end
		end
	end

	// rd_way_i is the hit way registered on the same edge as rd_q
	assign line_o = rd_q[rd_way_i];

endmodule

// ==== logic/icache_tag_top.sv ====
module icache_tag_top #(
	parameter int LINES = 64
) (
	input  logic clk,
	input  logic rst,
	input  logic ce_i,
	// Fill request
	input  logic fill_i,
	input  cpu_addr_pkg::address_t fill_vadr_i,
	input  cpu_addr_pkg::address_t fill_padr_i,
	input  cache_cfg_pkg::line_t fill_line_i,
	// Lookup by virtual address
	input  logic lookup_i,
	input  cpu_addr_pkg::address_t lookup_adr_i,
	// Snoop by physical address
	input  logic snoop_i,
	input  cpu_addr_pkg::address_t snoop_adr_i,
	// Results, one cycle after the request
	output logic lookup_valid_o,
	output logic hit_o,
	output cache_cfg_pkg::way_t hit_way_o,
	output cache_cfg_pkg::line_t line_o,
	output logic snoop_valid_o,
	output logic snoop_hit_o
);

	localparam int NDX_W = $clog2(LINES);
	localparam int HIBIT = cache_cfg_pkg::LOBIT + NDX_W - 1;

	// ==============================
	// Internal connections
	// ==============================

	cache_fill_if fill_bus ();

	cache_cfg_pkg::cache_tag_t [cache_cfg_pkg::WAYS-1:0] vtag;
	cache_cfg_pkg::cache_tag_t ptag [cache_cfg_pkg::WAYS][LINES];
	logic inv;
	cache_cfg_pkg::way_t inv_way;
	logic [NDX_W-1:0] inv_ndx;
	logic [NDX_W-1:0] lookup_ndx;
	logic [NDX_W-1:0] tag_ndx;

	assign lookup_ndx = lookup_adr_i[HIBIT:cache_cfg_pkg::LOBIT];

	// Virtual tag read index
	// A lookup owns the read port, a lone snoop uses it to check validity
	assign tag_ndx = lookup_i ? lookup_ndx : snoop_adr_i[HIBIT:cache_cfg_pkg::LOBIT];

	cache_fill_ctrl #(.LINES(LINES)) i_cache_fill_ctrl (
		.clk        (clk),
		.rst        (rst),
		.ce_i       (ce_i),
		.fill_i     (fill_i),
		.fill_vadr_i(fill_vadr_i),
		.fill_padr_i(fill_padr_i),
		.fill_line_i(fill_line_i),
		.fill       (fill_bus)
	);

	cache_tag_store #(.LINES(LINES)) i_cache_tag_store (
		.clk      (clk),
		.rst      (rst),
		.ce_i     (ce_i),
		.fill     (fill_bus),
		.ndx_i    (tag_ndx),
		.inv_i    (inv),
		.inv_way_i(inv_way),
		.inv_ndx_i(inv_ndx),
		.vtag_o   (vtag),
		.ptag_o   (ptag)
	);

	cache_tag_match #(.LINES(LINES)) i_cache_tag_match (
		.clk           (clk),
		.rst           (rst),
		.ce_i          (ce_i),
		.lookup_i      (lookup_i),
		.lookup_adr_i  (lookup_adr_i),
		.snoop_i       (snoop_i),
		.snoop_adr_i   (snoop_adr_i),
		.vtag_i        (vtag),
		.ptag_i        (ptag),
		.inv_o         (inv),
		.inv_way_o     (inv_way),
		.inv_ndx_o     (inv_ndx),
		.lookup_valid_o(lookup_valid_o),
		.hit_o         (hit_o),
		.hit_way_o     (hit_way_o),
		.snoop_valid_o (snoop_valid_o),
		.snoop_hit_o   (snoop_hit_o)
	);

	// Data read starts with the lookup and the way arrives from the matcher
	cache_data_store #(.LINES(LINES)) i_cache_data_store (
		.clk     (clk),
		.ce_i    (ce_i),
		.fill    (fill_bus),
		.rd_i    (lookup_i),
		.rd_ndx_i(lookup_ndx),
		.rd_way_i(hit_way_o),
		.line_o  (line_o)
	);

endmodule

// ==== tests/tb_icache_tag.sv ====
module tb_icache_tag;

	localparam int LINES = 64;
	localparam int TIMEOUT = 20;
	localparam int SEED = 32'h0714_9121;

	logic clk;
	logic rst;
	logic ce_i;
	logic fill_i;
	cpu_addr_pkg::address_t fill_vadr_i;
	cpu_addr_pkg::address_t fill_padr_i;
	cache_cfg_pkg::line_t fill_line_i;
	logic lookup_i;
	cpu_addr_pkg::address_t lookup_adr_i;
	logic snoop_i;
	cpu_addr_pkg::address_t snoop_adr_i;
	logic lookup_valid_o;
	logic hit_o;
	cache_cfg_pkg::way_t hit_way_o;
	cache_cfg_pkg::line_t line_o;
	logic snoop_valid_o;
	logic snoop_hit_o;

	int errors;
	int tests_run;

	// ==============================
	// Reference model
	// ==============================

	// Per set pointer, tags and lines
	// Tag value 1 marks an empty way
	logic [1:0] m_ptr [LINES];
	logic [18:0] m_vtag [4][LINES];
	logic [18:0] m_ptag [4][LINES];
	logic [511:0] m_line [4][LINES];

	icache_tag_top #(.LINES(LINES)) i_icache_tag_top (
		.clk           (clk),
		.rst           (rst),
		.ce_i          (ce_i),
		.fill_i        (fill_i),
		.fill_vadr_i   (fill_vadr_i),
		.fill_padr_i   (fill_padr_i),
		.fill_line_i   (fill_line_i),
		.lookup_i      (lookup_i),
		.lookup_adr_i  (lookup_adr_i),
		.snoop_i       (snoop_i),
		.snoop_adr_i   (snoop_adr_i),
		.lookup_valid_o(lookup_valid_o),
		.hit_o         (hit_o),
		.hit_way_o     (hit_way_o),
		.line_o        (line_o),
		.snoop_valid_o (snoop_valid_o),
		.snoop_hit_o   (snoop_hit_o)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Last resort against a stuck run
	initial begin
		#2000000;
		abort_run("Simulation ran past its time limit");
	end

	// Tag is address bits 31 to 13 and bit 12 is skipped
	function automatic logic [18:0] tag_of(input logic [31:0] adr);
		return adr[31:13];
	endfunction

	// Index is address bits 11 to 6
	function automatic logic [5:0] ndx_of(input logic [31:0] adr);
		return adr[11:6];
	endfunction

	task automatic report_value(input string name, input logic [511:0] got,
			input logic [511:0] exp);
		$display("CHECK FAILED %s got %0h expected %0h", name, got, exp);
		errors++;
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Testbench failed");
		$finish;
	endtask

	task automatic model_reset();
		for (int n = 0; n < LINES; n++) begin
			m_ptr[n] = 2'd0;
			for (int w = 0; w < 4; w++) begin
				m_vtag[w][n] = 19'd1;
				m_ptag[w][n] = 19'd0;
				m_line[w][n] = '0;
			end
		end
	endtask

	// The lowest way whose virtual tag matches gives the hit
	function automatic void model_lookup(input logic [31:0] adr, output logic hit,
			output logic [1:0] way);
		hit = 1'b0;
		way = 2'd0;
		for (int w = 3; w >= 0; w--) begin
			if (m_vtag[w][ndx_of(adr)] == tag_of(adr)) begin
				hit = 1'b1;
				way = w[1:0];
			end
		end
	endfunction

	// A snoop only sees ways that are still valid
	function automatic void model_snoop(input logic [31:0] adr, output logic hit,
			output logic [1:0] way);
		hit = 1'b0;
		way = 2'd0;
		for (int w = 3; w >= 0; w--) begin
			if (m_vtag[w][ndx_of(adr)] != 19'd1 && m_ptag[w][ndx_of(adr)] == tag_of(adr)) begin
				hit = 1'b1;
				way = w[1:0];
			end
		end
	endfunction

	function automatic logic [31:0] rand_vadr();
		logic [31:0] adr;
		do adr = $urandom; while (adr[31:13] == 19'd1);
		return adr;
	endfunction

	// A virtual address that no valid way holds yet
	function automatic logic [31:0] fresh_vadr();
		logic [31:0] adr;
		logic h;
		logic [1:0] w;
		do begin
			adr = rand_vadr();
			model_lookup(adr, h, w);
		end while (h);
		return adr;
	endfunction

	function automatic logic [31:0] fresh_padr();
		logic [31:0] adr;
		logic h;
		logic [1:0] w;
		do begin
			adr = $urandom;
			model_snoop(adr, h, w);
		end while (h);
		return adr;
	endfunction

	function automatic logic [511:0] rand_line();
		logic [511:0] l;
		for (int i = 0; i < 16; i++) begin
			l[i*32 +: 32] = $urandom;
		end
		return l;
	endfunction

	// ==============================
	// Bus level tasks
	// ==============================

	// One cycle fill pulse where the model takes the way from its own pointer
	task automatic do_fill(input logic [31:0] vadr, input logic [31:0] padr,
			input logic [511:0] line, output logic [1:0] way);
		way = m_ptr[ndx_of(vadr)];
		fill_vadr_i = vadr;
		fill_padr_i = padr;
		fill_line_i = line;
		fill_i = 1'b1;
		@(negedge clk);
		fill_i = 1'b0;
		m_vtag[way][ndx_of(vadr)] = tag_of(vadr);
		m_ptag[way][ndx_of(vadr)] = tag_of(padr);
		m_line[way][ndx_of(vadr)] = line;
		m_ptr[ndx_of(vadr)] = way + 2'd1;
	endtask

	task automatic check_lookup(input logic [31:0] adr, output logic got_hit,
			output logic [1:0] got_way);
		logic exp_hit;
		logic [1:0] exp_way;
		int cnt;
		model_lookup(adr, exp_hit, exp_way);
		lookup_adr_i = adr;
		lookup_i = 1'b1;
		@(negedge clk);
		lookup_i = 1'b0;
		cnt = 0;
		while (lookup_valid_o !== 1'b1 && cnt < TIMEOUT) begin
			@(negedge clk);
			cnt++;
		end
		if (lookup_valid_o !== 1'b1) begin
			$display("Lookup never raised lookup_valid_o");
			errors++;
		end else begin
			if (cnt != 0) begin
				$display("lookup_valid_o came %0d cycles late", cnt);
				errors++;
			end
			if (hit_o !== exp_hit) report_value("hit_o", hit_o, exp_hit);
			if (exp_hit && hit_way_o !== exp_way) report_value("hit_way_o", hit_way_o, exp_way);
			if (exp_hit && line_o !== m_line[exp_way][ndx_of(adr)]) begin
				report_value("line_o", line_o, m_line[exp_way][ndx_of(adr)]);
			end
		end
		got_hit = hit_o;
		got_way = hit_way_o;
	endtask

	// Snoops never share a cycle with a lookup
	task automatic do_snoop(input logic [31:0] adr, output logic got_hit);
		logic exp_hit;
		logic [1:0] exp_way;
		int cnt;
		model_snoop(adr, exp_hit, exp_way);
		snoop_adr_i = adr;
		snoop_i = 1'b1;
		@(negedge clk);
		snoop_i = 1'b0;
		cnt = 0;
		while (snoop_valid_o !== 1'b1 && cnt < TIMEOUT) begin
			@(negedge clk);
			cnt++;
		end
		if (snoop_valid_o !== 1'b1) begin
			$display("Snoop never raised snoop_valid_o");
			errors++;
		end else begin
			if (cnt != 0) begin
				$display("snoop_valid_o came %0d cycles late", cnt);
				errors++;
			end
			if (snoop_hit_o !== exp_hit) report_value("snoop_hit_o", snoop_hit_o, exp_hit);
		end
		if (exp_hit) m_vtag[exp_way][ndx_of(adr)] = 19'd1;
		got_hit = snoop_hit_o;
	endtask

	task automatic finish_test(input string name, input int start_errors);
		tests_run++;
		if (errors == start_errors) begin
			$display("%s: done, no errors", name);
		end else begin
			$display("%s: done, %0d errors", name, errors - start_errors);
		end
	endtask

	// ==============================
	// Directed tests
	// ==============================

	task automatic test_reset();
		int start;
		logic h;
		logic [1:0] w;
		start = errors;
		if (lookup_valid_o !== 1'b0) report_value("lookup_valid_o", lookup_valid_o, 1'b0);
		if (hit_o !== 1'b0) report_value("hit_o", hit_o, 1'b0);
		if (snoop_valid_o !== 1'b0) report_value("snoop_valid_o", snoop_valid_o, 1'b0);
		if (snoop_hit_o !== 1'b0) report_value("snoop_hit_o", snoop_hit_o, 1'b0);
		for (int i = 0; i < 4; i++) begin
			check_lookup(rand_vadr(), h, w);
			if (h !== 1'b0) report_value("hit_o", h, 1'b0);
		end
		finish_test("reset", start);
	endtask

	task automatic test_fill_lookup();
		int start;
		logic [31:0] vadr;
		logic [511:0] line;
		logic [1:0] way;
		logic h;
		logic [1:0] w;
		start = errors;
		for (int i = 0; i < 8; i++) begin
			vadr = fresh_vadr();
			line = rand_line();
			do_fill(vadr, $urandom, line, way);
			check_lookup(vadr, h, w);
			if (h !== 1'b1) report_value("hit_o", h, 1'b1);
			if (w !== way) report_value("hit_way_o", w, way);
			if (line_o !== line) report_value("line_o", line_o, line);
		end
		finish_test("fill_lookup", start);
	endtask

	task automatic test_round_robin();
		int start;
		int ndx;
		logic [18:0] base;
		logic [31:0] vadr [5];
		logic [1:0] way;
		logic h;
		logic [1:0] w;
		start = errors;
		// Pick a set that is still untouched so its pointer is at way zero
		ndx = -1;
		for (int n = LINES - 1; n >= 0; n--) begin
			if (m_ptr[n] == 2'd0 && m_vtag[0][n] == 19'd1) ndx = n;
		end
		if (ndx < 0) begin
			$display("No untouched set left for the round-robin test");
			errors++;
		end else begin
			base = 19'($urandom % 32'h7FFF0) + 19'd2;
			for (int i = 0; i < 5; i++) begin
				vadr[i] = {base + 19'(i), 1'b0, 6'(ndx), 6'h00};
				do_fill(vadr[i], $urandom, rand_line(), way);
			end
			// Fifth fill wrapped to way zero and pushed out the first tag
			check_lookup(vadr[0], h, w);
			if (h !== 1'b0) report_value("hit_o", h, 1'b0);
			for (int i = 1; i < 5; i++) begin
				check_lookup(vadr[i], h, w);
				if (h !== 1'b1) report_value("hit_o", h, 1'b1);
				if (w !== 2'(i % 4)) report_value("hit_way_o", w, 2'(i % 4));
			end
		end
		finish_test("round_robin", start);
	endtask

	task automatic test_snoop();
		int start;
		logic [31:0] vadr;
		logic [31:0] padr;
		logic [1:0] way;
		logic h;
		logic [1:0] w;
		start = errors;
		vadr = fresh_vadr();
		// The physical line shares the virtual index and no valid way holds it yet
		do begin
			padr = $urandom;
			padr[11:6] = vadr[11:6];
			model_snoop(padr, h, w);
		end while (h);
		do_fill(vadr, padr, rand_line(), way);
		do_snoop(padr, h);
		if (h !== 1'b1) report_value("snoop_hit_o", h, 1'b1);
		check_lookup(vadr, h, w);
		if (h !== 1'b0) report_value("hit_o", h, 1'b0);
		// The line is gone and a second snoop finds nothing
		do_snoop(padr, h);
		if (h !== 1'b0) report_value("snoop_hit_o", h, 1'b0);
		do_snoop(fresh_padr(), h);
		if (h !== 1'b0) report_value("snoop_hit_o", h, 1'b0);
		finish_test("snoop", start);
	endtask

	task automatic test_stall();
		int start;
		logic [31:0] vadr;
		logic [31:0] stall_vadr;
		logic [1:0] way;
		logic h;
		logic [1:0] w;
		logic snap_valid;
		logic snap_hit;
		logic [1:0] snap_way;
		logic [511:0] snap_line;
		start = errors;
		vadr = fresh_vadr();
		do_fill(vadr, $urandom, rand_line(), way);
		check_lookup(vadr, h, w);
		snap_valid = lookup_valid_o;
		snap_hit = hit_o;
		snap_way = hit_way_o;
		snap_line = line_o;
		// Clock enable drops while a fill and a lookup are both requested
		stall_vadr = fresh_vadr();
		ce_i = 1'b0;
		fill_vadr_i = stall_vadr;
		fill_padr_i = $urandom;
		fill_line_i = rand_line();
		fill_i = 1'b1;
		lookup_adr_i = stall_vadr;
		lookup_i = 1'b1;
		for (int i = 0; i < 3; i++) begin
			@(negedge clk);
			if (lookup_valid_o !== snap_valid) report_value("lookup_valid_o", lookup_valid_o, snap_valid);
			if (hit_o !== snap_hit) report_value("hit_o", hit_o, snap_hit);
			if (hit_way_o !== snap_way) report_value("hit_way_o", hit_way_o, snap_way);
			if (line_o !== snap_line) report_value("line_o", line_o, snap_line);
		end
		fill_i = 1'b0;
		lookup_i = 1'b0;
		ce_i = 1'b1;
		@(negedge clk);
		check_lookup(stall_vadr, h, w);
		if (h !== 1'b0) report_value("hit_o", h, 1'b0);
		finish_test("stall", start);
	endtask

	// ==============================
	// Main sequence
	// ==============================

	initial begin
		void'($urandom(SEED));
		errors = 0;
		tests_run = 0;
		rst = 1'b1;
		ce_i = 1'b1;
		fill_i = 1'b0;
		fill_vadr_i = '0;
		fill_padr_i = '0;
		fill_line_i = '0;
		lookup_i = 1'b0;
		lookup_adr_i = '0;
		snoop_i = 1'b0;
		snoop_adr_i = '0;
		model_reset();
		repeat (2) @(negedge clk);
		rst = 1'b0;
		test_reset();
		test_fill_lookup();
		test_round_robin();
		test_snoop();
		test_stall();
		$display("Tests run %0d, errors %0d", tests_run, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// ==== project.f ====
common/cpu_addr_pkg.sv
common/cache_cfg_pkg.sv
common/cache_fill_if.sv
cache_tag/cache_tag_store.sv
cache_tag/cache_tag_match.sv
logic/cache_fill_ctrl.sv
logic/cache_data_store.sv
logic/icache_tag_top.sv
tests/tb_icache_tag.sv

// ==== Bender.yml ====
package:
  name: icache_tag

sources:
  - common/cpu_addr_pkg.sv
  - common/cache_cfg_pkg.sv
  - common/cache_fill_if.sv
  - cache_tag/cache_tag_store.sv
  - cache_tag/cache_tag_match.sv
  - logic/cache_fill_ctrl.sv
  - logic/cache_data_store.sv
  - logic/icache_tag_top.sv
  - target: test
    files:
      - tests/tb_icache_tag.sv
